// File: Makefile
# Verilator build and run for the ADC capture buffer

VERILATOR ?= verilator
TOP       ?= tb_adc_capture
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
src/capture_pkg.sv
src/capture_fifo.sv
src/capture_control.sv
src/sample_packer.sv
src/byte_reader.sv
src/adc_capture_top.sv
tests/tb_adc_capture.sv

// File: src/adc_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top #(
    parameter int SAMPLE_DEPTH = capture_pkg::DEFAULT_SAMPLE_DEPTH,
    parameter int WORD_DEPTH   = capture_pkg::DEFAULT_WORD_DEPTH
) (
    input  wire                   adc_sampleclk,
    input  wire                   reset,
    input  wire capture_pkg::sample_t adc_data_i,
    input  wire                   adc_write_mask_i,
    input  wire                   arm_i,
    input  wire                   trigger_i,
    input  wire capture_pkg::count_t  presample_i,
    input  wire capture_pkg::count_t  max_samples_i,
    input  wire [12:0]            downsample_i,      // samples skipped between kept ones
    input  wire                   low_res_i,         // 8 bits per sample when set
    input  wire                   read_en_i,
    output wire capture_pkg::byte_t   read_data_o,
    output wire                   read_empty_o,
    output wire                   capture_stop_o,
    output wire                   error_o
);

    logic                 fifo_clear;
    logic                 capture_active;

    logic                 sample_wr;
    logic                 sample_rd;
    logic                 packer_rd;
    logic                 drain;
    capture_pkg::sample_t sample_dout;
    logic                 sample_full;
    logic                 sample_empty;
    logic                 sample_ovf;

    logic                 word_wr;
    capture_pkg::word_t   word_din;
    logic                 word_rd;
    capture_pkg::word_t   word_dout;
    logic                 word_full;
    logic                 word_empty;
    logic                 word_ovf;

    // history drain and packer never read in the same state
    assign sample_rd = packer_rd | drain;

    // lost samples or words, cleared on arm
    assign error_o = sample_ovf | word_ovf;

    capture_control capture_control_i (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .trigger_i        (trigger_i),
        .adc_write_mask_i (adc_write_mask_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .sample_full_i    (sample_full),
        .sample_empty_i   (sample_empty),
        .sample_wr_o      (sample_wr),
        .drain_o          (drain),
        .clear_o          (fifo_clear),
        .capture_active_o (capture_active),
        .capture_stop_o   (capture_stop_o)
    );

    capture_fifo #(
        .DEPTH     (SAMPLE_DEPTH),
        .PAYLOAD_T (capture_pkg::sample_t)
    ) sample_fifo_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (fifo_clear),
        .wr_i          (sample_wr),
        .din_i         (adc_data_i),
        .rd_i          (sample_rd),
        .dout_o        (sample_dout),
        .full_o        (sample_full),
        .empty_o       (sample_empty),
        .overflow_o    (sample_ovf)
    );

    sample_packer sample_packer_i (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .clear_i          (fifo_clear),
        .capture_active_i (capture_active),
        .sample_dout_i    (sample_dout),
        .sample_empty_i   (sample_empty),
        .word_full_i      (word_full),
        .sample_rd_o      (packer_rd),
        .word_wr_o        (word_wr),
        .word_din_o       (word_din)
    );

    capture_fifo #(
        .DEPTH     (WORD_DEPTH),
        .PAYLOAD_T (capture_pkg::word_t)
    ) word_fifo_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (fifo_clear),
        .wr_i          (word_wr),
        .din_i         (word_din),
        .rd_i          (word_rd),
        .dout_o        (word_dout),
        .full_o        (word_full),
        .empty_o       (word_empty),
        .overflow_o    (word_ovf)
    );

    byte_reader byte_reader_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (fifo_clear),
        .low_res_i     (low_res_i),
        .read_en_i     (read_en_i),
        .word_dout_i   (word_dout),
        .word_empty_i  (word_empty),
        .word_rd_o     (word_rd),
        .read_data_o   (read_data_o),
        .read_empty_o  (read_empty_o)
    );

endmodule

`default_nettype wire

// File: src/byte_reader.sv
`timescale 1ns/100ps
`default_nettype none

module byte_reader (
    input  wire                 adc_sampleclk,
    input  wire                 reset,
    input  wire                 clear_i,
    input  wire                 low_res_i,
    input  wire                 read_en_i,
    input  wire capture_pkg::word_t word_dout_i,
    input  wire                 word_empty_i,
    output logic                word_rd_o,
    output capture_pkg::byte_t  read_data_o,
    output logic                read_empty_o
);

    logic [3:0] cnt;                    // byte position within one or two words
    logic [3:0] nib_q;                  // low nibble of the first word in hi-res mode
    logic       take;
    logic       last_byte;

    // every byte needs the current head word
    assign read_empty_o = word_empty_i;
    assign take         = read_en_i && !word_empty_i;

    assign last_byte = low_res_i ? (cnt == 4'd2) : (cnt == 4'd8);
    assign word_rd_o = take && (last_byte || (!low_res_i && (cnt == 4'd3)));

    always_comb begin
        if (low_res_i) begin
            // top 8 bits of each sample
            case (cnt)
                4'd0:    read_data_o = word_dout_i[35:28];
                4'd1:    read_data_o = word_dout_i[23:16];
                4'd2:    read_data_o = word_dout_i[11:4];
                default: read_data_o = 8'h00;
            endcase
        end else begin
            // nine bytes carry two words
            case (cnt)
                4'd0:    read_data_o = word_dout_i[35:28];
                4'd1:    read_data_o = word_dout_i[27:20];
                4'd2:    read_data_o = word_dout_i[19:12];
                4'd3:    read_data_o = word_dout_i[11:4];
                4'd4:    read_data_o = {nib_q, word_dout_i[35:32]};  // split byte
                4'd5:    read_data_o = word_dout_i[31:24];
                4'd6:    read_data_o = word_dout_i[23:16];
                4'd7:    read_data_o = word_dout_i[15:8];
                4'd8:    read_data_o = word_dout_i[7:0];
                default: read_data_o = 8'h00;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            nib_q <= '0;
        end else if (take && !low_res_i && (cnt == 4'd3)) begin
            nib_q <= word_dout_i[3:0];      // first word leaves the fifo now
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            cnt <= '0;
        end else if (take) begin
            if (last_byte) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/capture_control.sv
`timescale 1ns/100ps
`default_nettype none

module capture_control (
    input  wire                  adc_sampleclk,
    input  wire                  reset,
    input  wire                  arm_i,
    input  wire                  trigger_i,
    input  wire                  adc_write_mask_i,
    input  wire capture_pkg::count_t presample_i,
    input  wire capture_pkg::count_t max_samples_i,
    input  wire [12:0]           downsample_i,
    input  wire                  sample_full_i,
    input  wire                  sample_empty_i,
    output logic                 sample_wr_o,
    output logic                 drain_o,
    output logic                 clear_o,
    output logic                 capture_active_o,
    output logic                 capture_stop_o
);

    capture_pkg::capture_state_t state_q;

    logic                arm_r;
    logic                arm_go;
    logic [12:0]         dec_ctr;
    logic                dec_tick;
    logic                kept;
    logic                in_presamp;
    logic                pre_wr;
    logic                post_wr;
    logic                accepted;
    logic                room;
    capture_pkg::count_t pre_count;       // samples held as history
    capture_pkg::count_t post_count;      // samples taken from the trigger on
    capture_pkg::count_t total;
    capture_pkg::count_t target_q;
    capture_pkg::count_t target_d;
    capture_pkg::count_t rem;

    // arming is only honoured from idle
    assign arm_go  = arm_i && !arm_r && (state_q == capture_pkg::IDLE);
    assign clear_o = arm_go;

    // every downsample_i+1 cycles, counted from the arm edge
    assign dec_tick = (dec_ctr == downsample_i);
    assign kept     = dec_tick && adc_write_mask_i;

    assign in_presamp = (state_q == capture_pkg::PRESAMP_FILLING) ||
                        (state_q == capture_pkg::PRESAMP_FULL);

    assign total = pre_count + post_count;
    assign room  = (total < target_q);

    // round up so the packer only ever sees whole words
    always_comb begin
        rem = max_samples_i % capture_pkg::count_t'(capture_pkg::SAMPLES_PER_WORD);
        if (rem == '0) begin
            target_d = max_samples_i;
        end else begin
            target_d = max_samples_i + capture_pkg::count_t'(capture_pkg::SAMPLES_PER_WORD) - rem;
        end
    end

    // history writes, none at all when no presamples are asked for
    assign pre_wr  = kept && in_presamp && !trigger_i && (presample_i != '0);
    // the trigger cycle's sample already belongs to the capture
    assign post_wr = kept && room &&
                     ((in_presamp && trigger_i) || (state_q == capture_pkg::TRIGGERED));

    assign sample_wr_o = pre_wr || post_wr;
    assign accepted    = sample_wr_o && !sample_full_i;

    // pop the oldest history sample alongside each new one
    assign drain_o = pre_wr && (state_q == capture_pkg::PRESAMP_FULL) && !sample_full_i;

    assign capture_active_o = (state_q == capture_pkg::TRIGGERED) ||
                              (state_q == capture_pkg::DONE);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r   <= 1'b0;
            dec_ctr <= '0;
        end else begin
            arm_r <= arm_i;
            if (arm_go || dec_tick) begin
                dec_ctr <= '0;
            end else begin
                dec_ctr <= dec_ctr + 13'd1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_q        <= capture_pkg::IDLE;
            pre_count      <= '0;
            post_count     <= '0;
            target_q       <= '0;
            capture_stop_o <= 1'b0;
        end else begin
            if (accepted && !trigger_i && (state_q == capture_pkg::PRESAMP_FILLING)) begin
                pre_count <= pre_count + 32'd1;
            end
            if (accepted && post_wr) begin
                post_count <= post_count + 32'd1;
            end

            case (state_q)
                capture_pkg::IDLE: begin
                    if (arm_go) begin
                        pre_count      <= '0;
                        post_count     <= '0;
                        target_q       <= target_d;
                        capture_stop_o <= 1'b0;
                        state_q        <= capture_pkg::PRESAMP_FILLING;
                    end
                end

                capture_pkg::PRESAMP_FILLING: begin
                    if (trigger_i) begin
                        state_q <= capture_pkg::TRIGGERED;
                    end else if (accepted && (pre_count == presample_i - 32'd1)) begin
                        state_q <= capture_pkg::PRESAMP_FULL;
                    end
                end

                capture_pkg::PRESAMP_FULL: begin
                    if (trigger_i) begin
                        state_q <= capture_pkg::TRIGGERED;
                    end
                end

                capture_pkg::TRIGGERED: begin
                    if (!room || (accepted && (total + 32'd1 >= target_q))) begin
                        capture_stop_o <= 1'b1;
                        state_q        <= capture_pkg::DONE;
                    end
                end

                capture_pkg::DONE: begin
                    // packer still owns whatever is left in the sample fifo
                    if (sample_empty_i) begin
                        state_q <= capture_pkg::IDLE;
                    end
                end

                default: state_q <= capture_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/capture_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module capture_fifo #(
    parameter int  DEPTH     = 8,
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  wire           adc_sampleclk,
    input  wire           reset,
    input  wire           clear_i,
    input  wire           wr_i,
    input  wire PAYLOAD_T din_i,
    input  wire           rd_i,
    output PAYLOAD_T      dout_o,
    output logic          full_o,
    output logic          empty_o,
    output logic          overflow_o
);

    localparam int AW = $clog2(DEPTH);

    PAYLOAD_T      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;              // one extra bit to tell full from empty
    logic          do_wr;
    logic          do_rd;

    assign full_o  = (count == (AW+1)'(DEPTH));
    assign empty_o = (count == '0);

    // first word fall through
    assign dout_o = mem[rd_ptr];

    assign do_wr = wr_i && !full_o;     // a write into a full buffer is lost
    assign do_rd = rd_i && !empty_o;    // read of an empty buffer is ignored

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle, or push and pop together
            endcase

            // sticky until the next arm
            if (wr_i && full_o) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/capture_pkg.sv
`default_nettype none

package capture_pkg;

    // payload types along the capture chain
    typedef logic [11:0] sample_t;      // one adc conversion
    typedef logic [35:0] word_t;        // three samples, oldest in [35:24]
    typedef logic [7:0]  byte_t;        // one byte on the read port

    // sample counts and limits
    typedef logic [31:0] count_t;

    // capture controller states
    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,                // collecting pretrigger history
        PRESAMP_FULL,                   // history full, oldest sample dropped per write
        TRIGGERED,
        DONE                            // waiting for the sample fifo to drain
    } capture_state_t;

    localparam int SAMPLES_PER_WORD = 3;

    // fifo depths, must be powers of two
    localparam int DEFAULT_SAMPLE_DEPTH = 64;
    localparam int DEFAULT_WORD_DEPTH   = 256;

endpackage

`default_nettype wire

// File: src/sample_packer.sv
`timescale 1ns/100ps
`default_nettype none

module sample_packer (
    input  wire                   adc_sampleclk,
    input  wire                   reset,
    input  wire                   clear_i,
    input  wire                   capture_active_i,
    input  wire capture_pkg::sample_t sample_dout_i,
    input  wire                   sample_empty_i,
    input  wire                   word_full_i,
    output logic                  sample_rd_o,
    output logic                  word_wr_o,
    output capture_pkg::word_t    word_din_o
);

    localparam int LAST = capture_pkg::SAMPLES_PER_WORD - 1;

    capture_pkg::word_t word_q;         // shift register, newest sample at the bottom
    logic [1:0]         cnt;
    logic               push_q;

    // a full word fifo holds everything back
    assign sample_rd_o = capture_active_i && !sample_empty_i && !word_full_i;

    assign word_wr_o  = push_q;
    assign word_din_o = word_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            word_q <= '0;
        end else if (sample_rd_o) begin
            word_q <= {word_q[23:0], sample_dout_i};
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            cnt    <= '0;
            push_q <= 1'b0;
        end else begin
            push_q <= 1'b0;
            if (sample_rd_o) begin
                if (cnt == 2'(LAST)) begin
                    cnt    <= '0;
                    push_q <= 1'b1;     // word complete, written next cycle
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/capture_stimulus.txt
# id presample max_samples downsample mask_mode trigger_cycle low_res expected_count
# mask_mode 0 keeps every tick, 1 draws the write mask at random
1    0   30   0   0    5   1   30
2    0   31   0   0   10   1   33
3    0   36   0   0    7   0   36
4   16   60   0   0   40   1   60
5   20   48   0   0    8   0   48
6    0   25   3   0   12   1   27
7    8   47   2   0   50   0   48
8    0   40   0   1    6   1   42
9   12   70   1   1   60   0   72
10  32  200   0   0  100   1  201
11   4   12   5   1   30   0   12
12   0    1   0   0    3   1    3

// File: tests/tb_adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture;

    localparam int MAX_TESTS    = 16;
    localparam int QUIET_CYCLES = 32;   // empty cycles that end a readout

    logic                 adc_sampleclk = 1'b0;
    logic                 reset;
    capture_pkg::sample_t adc_data_i;
    logic                 adc_write_mask_i;
    logic                 arm_i;
    logic                 trigger_i;
    capture_pkg::count_t  presample_i;
    capture_pkg::count_t  max_samples_i;
    logic [12:0]          downsample_i;
    logic                 low_res_i;
    logic                 read_en_i;
    capture_pkg::byte_t   read_data_o;
    logic                 read_empty_o;
    logic                 capture_stop_o;
    logic                 error_o;

    // one entry per stimulus record
    int t_id   [MAX_TESTS];
    int t_pre  [MAX_TESTS];
    int t_max  [MAX_TESTS];
    int t_ds   [MAX_TESTS];
    int t_mask [MAX_TESTS];
    int t_trig [MAX_TESTS];
    int t_low  [MAX_TESTS];
    int t_exp  [MAX_TESTS];

    int     ntests;
    int     seed = 73547;
    int     rnd;
    int     cyc;                        // ramp value for the next cycle
    int     mask_mode;
    int     nerr;
    int     npass;
    int     nfail;
    longint limit_ns;
    bit     limit_ready;
    bit     file_ok;

    always #4 adc_sampleclk = ~adc_sampleclk;

    adc_capture_top adc_capture_top_i (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_data_i       (adc_data_i),
        .adc_write_mask_i (adc_write_mask_i),
        .arm_i            (arm_i),
        .trigger_i        (trigger_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .low_res_i        (low_res_i),
        .read_en_i        (read_en_i),
        .read_data_o      (read_data_o),
        .read_empty_o     (read_empty_o),
        .capture_stop_o   (capture_stop_o),
        .error_o          (error_o)
    );

    // falling edge, ramp and mask for the coming rising edge
    task automatic next_cycle();
        @(negedge adc_sampleclk);
        adc_data_i = cyc[11:0];
        cyc = cyc + 1;
        if (mask_mode == 1) begin
            rnd = $random(seed);
            adc_write_mask_i = rnd[0];
        end else begin
            adc_write_mask_i = 1'b1;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        int    id, pre, mx, ds, mm, trig, lr, expn;
        string line;
        fd = $fopen("tests/capture_stimulus.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d",
                            id, pre, mx, ds, mm, trig, lr, expn);
                if (n == 8 && ntests < MAX_TESTS) begin   // comment lines scan as 0
                    t_id[ntests]   = id;
                    t_pre[ntests]  = pre;
                    t_max[ntests]  = mx;
                    t_ds[ntests]   = ds;
                    t_mask[ntests] = mm;
                    t_trig[ntests] = trig;
                    t_low[ntests]  = lr;
                    t_exp[ntests]  = expn;
                    limit_ns = limit_ns + longint'(8 * (trig + 4 * mx * (ds + 1) + 200));
                    ntests++;
                end
            end
            $fclose(fd);
            limit_ready = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        logic [11:0]        pre_log [$];
        logic [11:0]        post_log [$];
        logic [11:0]        pred [$];
        logic [11:0]        back [$];
        capture_pkg::byte_t got [$];
        logic [11:0]        trig_val;
        logic [11:0]        diff;
        logic [71:0]        grp;
        int                 i;
        int                 j;
        int                 k;
        int                 quiet;
        int                 npre;
        int                 rounded;
        int                 nread;
        int                 lead;
        int                 err_start;
        bit                 stopped;

        err_start = nerr;
        rounded   = (t_max[idx] + 2) / 3 * 3;     // whole packed words only
        assert (t_exp[idx] == rounded) else begin
            $display("mismatch at %0t: test %0d record count %0d, rounded target %0d",
                     $time, t_id[idx], t_exp[idx], rounded);
            nerr++;
        end

        presample_i   = t_pre[idx];
        max_samples_i = t_max[idx];
        downsample_i  = 13'(t_ds[idx]);
        low_res_i     = (t_low[idx] != 0);
        mask_mode     = t_mask[idx];
        trig_val      = '0;

        next_cycle();
        arm_i = 1'b1;                   // arm edge is cycle 0
        k = 1;
        stopped = 1'b0;
        while (!stopped) begin
            next_cycle();
            arm_i     = 1'b0;
            trigger_i = (k == t_trig[idx]);
            if (k == 1) begin
                assert (!capture_stop_o) else begin
                    $display("capture_stop_o did not clear on arming in test %0d", t_id[idx]);
                    nerr++;
                end
            end
            if (trigger_i) begin
                trig_val = adc_data_i;
            end
            // kept sample log, split at the trigger cycle
            if ((k % (t_ds[idx] + 1) == 0) && adc_write_mask_i) begin
                if (k < t_trig[idx]) begin
                    pre_log.push_back(adc_data_i);
                end else begin
                    post_log.push_back(adc_data_i);
                end
            end
            stopped = capture_stop_o && (k > 1);
            k++;
        end
        trigger_i = 1'b0;

        // newest history first, then post trigger samples up to the target
        npre = (pre_log.size() < t_pre[idx]) ? pre_log.size() : t_pre[idx];
        for (i = pre_log.size() - npre; i < pre_log.size(); i++) begin
            pred.push_back(pre_log[i]);
        end
        for (i = 0; i < post_log.size() && pred.size() < rounded; i++) begin
            pred.push_back(post_log[i]);
        end

        read_en_i = 1'b1;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            if (!read_empty_o) begin
                got.push_back(read_data_o);     // consumed on the next rising edge
                quiet = 0;
            end else begin
                quiet++;
            end
            next_cycle();
        end
        read_en_i = 1'b0;

        if (low_res_i) begin
            nread = got.size();
            for (i = 0; i < nread && i < pred.size(); i++) begin
                assert (got[i] == pred[i][11:4]) else begin
                    $display("mismatch at %0t: test %0d byte %0d is %h, expected %h",
                             $time, t_id[idx], i, got[i], pred[i][11:4]);
                    nerr++;
                end
            end
        end else begin
            assert (got.size() % 9 == 0) else begin
                $display("test %0d readout stopped inside a nine byte group", t_id[idx]);
                nerr++;
            end
            // nine bytes are two words, six samples msb first
            for (i = 0; i + 9 <= got.size(); i += 9) begin
                grp = '0;
                for (j = 0; j < 9; j++) begin
                    grp = {grp[63:0], got[i + j]};
                end
                for (j = 0; j < 6; j++) begin
                    back.push_back(grp[71 - 12 * j -: 12]);
                end
            end
            nread = back.size();
            for (i = 0; i < nread && i < pred.size(); i++) begin
                assert (back[i] == pred[i]) else begin
                    $display("mismatch at %0t: test %0d sample %0d is %h, expected %h",
                             $time, t_id[idx], i, back[i], pred[i]);
                    nerr++;
                end
            end
            if (t_pre[idx] > 0) begin
                lead = 0;
                while (lead < back.size()) begin
                    diff = trig_val - back[lead];   // ramp distance, wraps at 4096
                    if (diff == 12'd0 || diff >= 12'd2048) begin
                        break;
                    end
                    lead++;
                end
                assert (lead == npre) else begin
                    $display("mismatch at %0t: test %0d has %0d history samples, expected %0d",
                             $time, t_id[idx], lead, npre);
                    nerr++;
                end
            end
        end

        assert (nread == rounded) else begin
            $display("mismatch at %0t: test %0d read %0d samples, expected %0d",
                     $time, t_id[idx], nread, rounded);
            nerr++;
        end
        assert (pred.size() == rounded) else begin
            $display("test %0d kept fewer samples than its capture target", t_id[idx]);
            nerr++;
        end
        assert (capture_stop_o) else begin
            $display("test %0d did not end with capture_stop_o high", t_id[idx]);
            nerr++;
        end
        assert (!error_o) else begin
            $display("error_o went high during test %0d", t_id[idx]);
            nerr++;
        end

        if (nerr == err_start) begin
            npass++;
        end else begin
            nfail++;
        end
        $display("test %0d: presample %0d max %0d downsample %0d %s res, %0d samples, %s",
                 t_id[idx], t_pre[idx], t_max[idx], t_ds[idx],
                 low_res_i ? "low" : "high", nread, (nerr == err_start) ? "pass" : "FAIL");
    endtask

    initial begin
        int t;
        reset            = 1'b1;
        adc_data_i       = '0;
        adc_write_mask_i = 1'b1;
        arm_i            = 1'b0;
        trigger_i        = 1'b0;
        presample_i      = '0;
        max_samples_i    = '0;
        downsample_i     = '0;
        low_res_i        = 1'b1;
        read_en_i        = 1'b0;
        cyc              = 0;
        mask_mode        = 0;
        nerr             = 0;
        npass            = 0;
        nfail            = 0;
        ntests           = 0;
        limit_ns         = 0;
        limit_ready      = 1'b0;

        load_tests();
        if (!file_ok) begin
            $display("could not open tests/capture_stimulus.txt");
            $display("Test failed");
            $finish;
        end else begin
            repeat (16) begin
                next_cycle();
            end
            reset = 1'b0;
            cyc   = 0;
            for (t = 0; t < ntests; t++) begin
                run_test(t);
            end
            $display("%0d tests passed, %0d failed", npass, nfail);
            if (nfail == 0 && ntests > 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // run length from the records
    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("run timed out waiting for capture or readout");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
